// File: rtl/heap_pkg.sv
`default_nettype none

package heap_pkg;

  // ----------------------------------------------------------------------
  // key and tree geometry
  // ----------------------------------------------------------------------
  localparam int DATA_WIDTH = 16;  // key width
  localparam int TREE_DEPTH = 4;   // levels, root included
  localparam int NODES      = 15;  // K, total heap slots
  localparam int RAM_NODES  = 14;  // nodes 1..14, node 0 is the root register

  localparam int ADDR_WIDTH  = 4;  // flat node index width
  localparam int COUNT_WIDTH = 4;  // occupancy 0..NODES

  // first leaf in flat order, nodes from here down have no children
  localparam int FIRST_LEAF = (1 << (TREE_DEPTH - 1)) - 1;

  // clear writes two nodes per cycle
  localparam int CLEAR_PAIRS = RAM_NODES / 2;

  // ----------------------------------------------------------------------
  // types
  // ----------------------------------------------------------------------
  typedef logic [DATA_WIDTH-1:0]  data_t;   // zero marks an empty slot
  typedef logic [ADDR_WIDTH-1:0]  addr_t;   // node n -> children 2n+1, 2n+2
  typedef logic [COUNT_WIDTH-1:0] count_t;

  // who drives the node RAM
  typedef enum logic {
    OWNER_CLEAR = 1'b0,  // zeroing after reset
    OWNER_SIFT  = 1'b1   // normal operation
  } owner_t;

endpackage

`default_nettype wire

// File: rtl/heap_node_ram.sv
`timescale 1ns/1ps
`default_nettype none

module heap_node_ram
  import heap_pkg::*;
(
  input  wire logic  CLK,
  // port a
  input  wire addr_t i_addr_a,
  input  wire data_t i_wdata_a,
  input  wire logic  i_we_a,
  output data_t      o_rdata_a,   // valid one cycle after address
  // port b
  input  wire addr_t i_addr_b,
  input  wire data_t i_wdata_b,
  input  wire logic  i_we_b,
  output data_t      o_rdata_b
);

  // ----------------------------------------------------------------------
  // storage, indexed by flat node number
  // ----------------------------------------------------------------------
  data_t mem [NODES];  // slot 0 never touched, root lives in a register

  // writes, both ports
  always_ff @(posedge CLK) begin : ram_write
    if (i_we_a) begin
      mem[i_addr_a] <= i_wdata_a;
    end
    if (i_we_b) begin
      mem[i_addr_b] <= i_wdata_b;
    end
  end

  // registered reads, old data on a same-cycle write
  always_ff @(posedge CLK) begin : ram_read
    o_rdata_a <= mem[i_addr_a];
    o_rdata_b <= mem[i_addr_b];
  end

  // ----------------------------------------------------------------------
  // checks
  // ----------------------------------------------------------------------
  // clear and sift both promise disjoint node pairs
  a_no_write_collision : assert property (
    @(posedge CLK) !(i_we_a && i_we_b && (i_addr_a == i_addr_b))
  ) else $error("both ports write node %0d", i_addr_a);

endmodule

`default_nettype wire

// File: rtl/ram_port_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module ram_port_arbiter
  import heap_pkg::*;
(
  input  wire logic  CLK,
  input  wire logic  RSTn,
  // clear sequencer side
  input  wire logic  i_clr_req,
  input  wire addr_t i_clr_addr_a,
  input  wire addr_t i_clr_addr_b,
  input  wire logic  i_clr_we,
  // sift engine side
  input  wire addr_t i_sift_addr_a,
  input  wire addr_t i_sift_addr_b,
  input  wire data_t i_sift_wdata_a,
  input  wire data_t i_sift_wdata_b,
  input  wire logic  i_sift_we_a,
  input  wire logic  i_sift_we_b,
  output logic       o_sift_grant,   // level, stays up until next reset
  // node ram
  output addr_t      o_ram_addr_a,
  output data_t      o_ram_wdata_a,
  output logic       o_ram_we_a,
  output addr_t      o_ram_addr_b,
  output data_t      o_ram_wdata_b,
  output logic       o_ram_we_b
);

  owner_t owner_q;

  // ----------------------------------------------------------------------
  // one-way handover, clear -> sift
  // ----------------------------------------------------------------------
  always_ff @(posedge CLK or negedge RSTn) begin : owner_seq
    if (!RSTn) begin
      owner_q <= OWNER_CLEAR;
    end else if ((owner_q == OWNER_CLEAR) && !i_clr_req) begin
      owner_q <= OWNER_SIFT;  // last pair written
    end
  end

  assign o_sift_grant = (owner_q == OWNER_SIFT);

  // port mux, both ports follow the same owner
  always_comb begin : port_mux
    if (owner_q == OWNER_SIFT) begin
      o_ram_addr_a  = i_sift_addr_a;
      o_ram_wdata_a = i_sift_wdata_a;
      o_ram_we_a    = i_sift_we_a;
      o_ram_addr_b  = i_sift_addr_b;
      o_ram_wdata_b = i_sift_wdata_b;
      o_ram_we_b    = i_sift_we_b;
    end else begin
      o_ram_addr_a  = i_clr_addr_a;
      o_ram_wdata_a = '0;          // clear path only ever writes zero
      o_ram_we_a    = i_clr_we;
      o_ram_addr_b  = i_clr_addr_b;
      o_ram_wdata_b = '0;
      o_ram_we_b    = i_clr_we;
    end
  end

  // sift writes during the clear would be dropped silently
  a_sift_write_granted : assert property (
    @(posedge CLK) disable iff (!RSTn)
    (i_sift_we_a || i_sift_we_b) |-> (owner_q == OWNER_SIFT)
  ) else $error("sift engine wrote without grant");

endmodule

`default_nettype wire

// File: rtl/ram_clear_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module ram_clear_sequencer
  import heap_pkg::*;
(
  input  wire logic CLK,
  input  wire logic RSTn,
  output logic      o_req,     // high until the last pair is written
  output addr_t     o_addr_a,  // odd node of the pair
  output addr_t     o_addr_b,  // even node of the pair
  output logic      o_we
);

  // ----------------------------------------------------------------------
  // node pair walk, pair p covers nodes 2p+1 and 2p+2
  // ----------------------------------------------------------------------
  logic [ADDR_WIDTH-2:0] pair_q;   // 0..CLEAR_PAIRS, parks at CLEAR_PAIRS
  logic                  req_q;
  logic                  last_pair;

  assign last_pair = (pair_q == (ADDR_WIDTH-1)'(CLEAR_PAIRS - 1));

  always_ff @(posedge CLK or negedge RSTn) begin : clear_seq
    if (!RSTn) begin
      pair_q <= '0;
      req_q  <= 1'b1;  // ram owned by the clear from reset on
    end else if (req_q) begin
      pair_q <= pair_q + 1'b1;
      if (last_pair) begin
        req_q <= 1'b0;  // drops on the edge writing nodes 13, 14
      end
    end
  end

  assign o_req    = req_q;
  assign o_we     = (pair_q != (ADDR_WIDTH-1)'(CLEAR_PAIRS));  // still pairs left
  assign o_addr_a = {pair_q, 1'b1};                 // 2p+1
  assign o_addr_b = {pair_q, 1'b0} + addr_t'(2);    // 2p+2

  // counter and request must agree on when the walk is over
  a_we_inside_req : assert property (
    @(posedge CLK) disable iff (!RSTn)
    o_we |-> o_req
  ) else $error("clear write after request dropped, pair %0d", pair_q);

endmodule

`default_nettype wire

// File: rtl/sift_down_engine.sv
`timescale 1ns/1ps
`default_nettype none

module sift_down_engine
  import heap_pkg::*;
(
  input  wire logic  CLK,
  input  wire logic  RSTn,
  input  wire logic  i_grant,    // ram handed over by the arbiter
  // offer
  input  wire logic  i_wrt,
  input  wire data_t i_data,
  // status
  output logic       o_busy,
  output logic       o_full,
  output data_t      o_root,     // node 0, smallest value held
  // ram ports, through the arbiter
  output addr_t      o_addr_a,
  output addr_t      o_addr_b,
  output data_t      o_wdata_a,
  output data_t      o_wdata_b,
  output logic       o_we_a,
  output logic       o_we_b,
  input  wire data_t i_rdata_a,  // left child after READ_CHILDREN
  input  wire data_t i_rdata_b   // right child
);

  // ----------------------------------------------------------------------
  // state
  // ----------------------------------------------------------------------
  typedef enum logic [1:0] {
    IDLE          = 2'd0,
    READ_CHILDREN = 2'd1,  // child addresses out on a and b
    COMPARE_WRITE = 2'd2   // children back, pick and write
  } state_t;

  state_t state_q, state_d;
  data_t  root_q, root_d;
  data_t  val_q, val_d;      // the sinking value
  addr_t  idx_q, idx_d;      // slot the sinking value currently owns
  count_t count_q, count_d;  // nonzero entries

  logic   accept;
  addr_t  left_idx;
  addr_t  right_idx;
  data_t  small_val;
  addr_t  small_idx;
  logic   sink_more;      // smaller child is below the sinking value
  logic   small_is_leaf;

  // ----------------------------------------------------------------------
  // offer qualification and child selection
  // ----------------------------------------------------------------------
  assign o_busy = !i_grant || (state_q != IDLE);  // clear still running or sifting
  assign accept = i_wrt && !o_busy && (i_data > root_q);

  assign left_idx  = {idx_q[ADDR_WIDTH-2:0], 1'b1};  // 2n+1, idx stays below FIRST_LEAF
  assign right_idx = left_idx + addr_t'(1);          // 2n+2

  always_comb begin : pick_child
    if (i_rdata_b < i_rdata_a) begin
      small_val = i_rdata_b;
      small_idx = right_idx;
    end else begin
      small_val = i_rdata_a;  // ties go left
      small_idx = left_idx;
    end
  end

  assign sink_more     = (small_val < val_q);              // equal stops the sift
  assign small_is_leaf = (small_idx >= addr_t'(FIRST_LEAF));

  // ----------------------------------------------------------------------
  // fsm and datapath next state
  // ----------------------------------------------------------------------
  always_comb begin : sift_comb
    state_d = state_q;
    root_d  = root_q;
    val_d   = val_q;
    idx_d   = idx_q;
    count_d = count_q;
    case (state_q)
      IDLE: begin
        if (accept) begin
          root_d  = i_data;  // overwrite root, visible next cycle
          val_d   = i_data;
          idx_d   = '0;
          state_d = READ_CHILDREN;
          if (root_q == '0) begin
            count_d = count_q + count_t'(1);  // replaced an empty slot
          end
        end
      end

      READ_CHILDREN: begin
        state_d = COMPARE_WRITE;  // ram read latency
      end

      COMPARE_WRITE: begin
        state_d = IDLE;
        if (sink_more) begin
          if (idx_q == '0) begin
            root_d = small_val;  // child moves up into the root reg
          end
          if (!small_is_leaf) begin
            idx_d   = small_idx;  // one level down
            state_d = READ_CHILDREN;
          end
        end
        // otherwise val_q lands in idx_q, root already holds it at node 0
      end

      default: begin
        state_d = IDLE;
      end
    endcase
  end

  // ram port drive
  always_comb begin : port_comb
    o_addr_a  = left_idx;   // read pair by default
    o_addr_b  = right_idx;
    o_wdata_a = val_q;
    o_wdata_b = val_q;      // b only writes the sinking value into a leaf
    o_we_a    = 1'b0;
    o_we_b    = 1'b0;
    if (state_q == COMPARE_WRITE) begin
      o_addr_a = idx_q;
      o_addr_b = small_idx;
      if (sink_more) begin
        o_wdata_a = small_val;  // swap up
      end
      o_we_a = (idx_q != '0);                 // node 0 is not in the ram
      o_we_b = sink_more && small_is_leaf;    // bottom reached, park the value
    end
  end

  // ----------------------------------------------------------------------
  // registers
  // ----------------------------------------------------------------------
  always_ff @(posedge CLK or negedge RSTn) begin : ctrl_seq
    if (!RSTn) begin
      state_q <= IDLE;
      root_q  <= '0;
      count_q <= '0;
    end else begin
      state_q <= state_d;
      root_q  <= root_d;
      count_q <= count_d;
    end
  end

  always_ff @(posedge CLK) begin : payload_seq
    val_q <= val_d;
    idx_q <= idx_d;
  end

  assign o_root = root_q;
  assign o_full = (count_q == count_t'(NODES));

  // ----------------------------------------------------------------------
  // checks
  // ----------------------------------------------------------------------
  // a zero root at K entries would wrap the four bit count
  a_count_bound : assert property (
    @(posedge CLK) disable iff (!RSTn)
    (accept && (root_q == '0)) |-> (count_q != count_t'(NODES))
  ) else $error("occupancy would pass K, count %0d", count_q);

  // a sift only lowers the root, a taken offer would raise it
  a_no_offer_while_busy : assert property (
    @(posedge CLK) disable iff (!RSTn)
    o_busy |=> (root_q <= $past(root_q))
  ) else $error("root rose after a busy cycle");

endmodule

`default_nettype wire

// File: rtl/topk_heap_top.sv
`timescale 1ns/1ps
`default_nettype none

module topk_heap_top
  import heap_pkg::*;
(
  input  wire logic  CLK,
  input  wire logic  RSTn,
  input  wire logic  i_wrt,   // offer strobe
  input  wire data_t i_data,
  output data_t      o_data,  // K-th largest seen once full
  output logic       o_busy,
  output logic       o_full
);

  // ----------------------------------------------------------------------
  // interconnect
  // ----------------------------------------------------------------------
  // clear sequencer -> arbiter
  logic  clr_req;
  addr_t clr_addr_a;
  addr_t clr_addr_b;
  logic  clr_we;

  // sift engine <-> arbiter
  logic  sift_grant;
  addr_t sift_addr_a;
  addr_t sift_addr_b;
  data_t sift_wdata_a;
  data_t sift_wdata_b;
  logic  sift_we_a;
  logic  sift_we_b;

  // arbiter -> ram, ram -> sift engine
  addr_t ram_addr_a;
  addr_t ram_addr_b;
  data_t ram_wdata_a;
  data_t ram_wdata_b;
  logic  ram_we_a;
  logic  ram_we_b;
  data_t ram_rdata_a;
  data_t ram_rdata_b;

  // ----------------------------------------------------------------------
  // instances
  // ----------------------------------------------------------------------
  ram_clear_sequencer u_clear (
    .CLK      (CLK),
    .RSTn     (RSTn),
    .o_req    (clr_req),
    .o_addr_a (clr_addr_a),
    .o_addr_b (clr_addr_b),
    .o_we     (clr_we)
  );

  sift_down_engine u_sift (
    .CLK       (CLK),
    .RSTn      (RSTn),
    .i_grant   (sift_grant),
    .i_wrt     (i_wrt),
    .i_data    (i_data),
    .o_busy    (o_busy),
    .o_full    (o_full),
    .o_root    (o_data),
    .o_addr_a  (sift_addr_a),
    .o_addr_b  (sift_addr_b),
    .o_wdata_a (sift_wdata_a),
    .o_wdata_b (sift_wdata_b),
    .o_we_a    (sift_we_a),
    .o_we_b    (sift_we_b),
    .i_rdata_a (ram_rdata_a),  // read data goes straight back
    .i_rdata_b (ram_rdata_b)
  );

  ram_port_arbiter u_arb (
    .CLK            (CLK),
    .RSTn           (RSTn),
    .i_clr_req      (clr_req),
    .i_clr_addr_a   (clr_addr_a),
    .i_clr_addr_b   (clr_addr_b),
    .i_clr_we       (clr_we),
    .i_sift_addr_a  (sift_addr_a),
    .i_sift_addr_b  (sift_addr_b),
    .i_sift_wdata_a (sift_wdata_a),
    .i_sift_wdata_b (sift_wdata_b),
    .i_sift_we_a    (sift_we_a),
    .i_sift_we_b    (sift_we_b),
    .o_sift_grant   (sift_grant),
    .o_ram_addr_a   (ram_addr_a),
    .o_ram_wdata_a  (ram_wdata_a),
    .o_ram_we_a     (ram_we_a),
    .o_ram_addr_b   (ram_addr_b),
    .o_ram_wdata_b  (ram_wdata_b),
    .o_ram_we_b     (ram_we_b)
  );

  heap_node_ram u_ram (
    .CLK       (CLK),
    .i_addr_a  (ram_addr_a),
    .i_wdata_a (ram_wdata_a),
    .i_we_a    (ram_we_a),
    .o_rdata_a (ram_rdata_a),
    .i_addr_b  (ram_addr_b),
    .i_wdata_b (ram_wdata_b),
    .i_we_b    (ram_we_b),
    .o_rdata_b (ram_rdata_b)
  );

endmodule

`default_nettype wire

// File: testbench/tb_topk_heap.sv
`timescale 1ns/1ps
`default_nettype none

module tb_topk_heap
  import heap_pkg::*;
();

  // ----------------------------------------------------------------------
  // run constants
  // ----------------------------------------------------------------------
  localparam int          HAND_LEN       = 36;
  localparam int          RAND_LEN       = 200;
  localparam int          TABLE_LEN      = HAND_LEN + RAND_LEN;
  localparam logic [31:0] SEED           = 32'h90cc_62ab;
  localparam int          TIMEOUT_CYCLES = TABLE_LEN * 8 + 50;  // worst sift plus margin
  localparam int          IDLE_WAIT      = 10;                  // clear or one sift

  logic  CLK;
  logic  RSTn;
  logic  i_wrt;
  data_t i_data;
  data_t o_data;
  logic  o_busy;
  logic  o_full;

  int error_count = 0;
  int check_count = 0;
  int cycle_count = 0;
  int step        = 0;  // table index, shown in error lines

  data_t model [NODES];           // reference slots, zero is empty
  data_t stim_val [TABLE_LEN];
  bit    stim_offer [TABLE_LEN];  // 0 = stray pulse inside a busy window

  // fill phase, rejects, strays, then duplicate and tie runs
  data_t hand_val [HAND_LEN] = '{
    16'd0,    16'd500,  16'hffff, 16'd120,  16'd900,  16'd60,
    16'd300,  16'd750,  16'd40,   16'd1000, 16'd220,  16'd80,
    16'd640,  16'd10,   16'd410,  16'd870,  16'd150,  16'd10,
    16'd5,    16'd0,    16'd11,   16'h8000, 16'd11,   16'd40,
    16'd45,   16'd45,   16'd45,   16'd61,   16'd61,   16'd61,
    16'd61,   16'd62,   16'hfffe, 16'd1000, 16'd1000, 16'hffff
  };
  bit hand_offer [HAND_LEN] = '{
    1'b1, 1'b1, 1'b0, 1'b1, 1'b1, 1'b1, 1'b1, 1'b1, 1'b1, 1'b1, 1'b1, 1'b1,
    1'b1, 1'b1, 1'b1, 1'b1, 1'b1, 1'b1, 1'b1, 1'b1, 1'b1, 1'b0, 1'b1, 1'b1,
    1'b1, 1'b1, 1'b1, 1'b1, 1'b1, 1'b1, 1'b1, 1'b1, 1'b0, 1'b1, 1'b1, 1'b1
  };

  topk_heap_top UUT (
    .CLK    (CLK),
    .RSTn   (RSTn),
    .i_wrt  (i_wrt),
    .i_data (i_data),
    .o_data (o_data),
    .o_busy (o_busy),
    .o_full (o_full)
  );

  initial begin : clock_gen
    CLK = 1'b0;
    forever #20 CLK = ~CLK;  // 40 ns period
  end

  // ----------------------------------------------------------------------
  // stimulus generation and reference model
  // ----------------------------------------------------------------------
  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic build_table();
    int          i;
    logic [31:0] x;
    data_t       prev;
    x    = SEED;
    prev = 16'd1;
    for (i = 0; i < HAND_LEN; i++) begin
      stim_val[i]   = hand_val[i];
      stim_offer[i] = hand_offer[i];
    end
    for (i = 0; i < RAND_LEN; i++) begin
      x = xorshift32(x);
      if (x[31:29] == 3'd0) begin
        stim_val[HAND_LEN+i] = prev;  // repeat, hits ties and equal roots
      end else begin
        stim_val[HAND_LEN+i] = x[15:0];
      end
      stim_offer[HAND_LEN+i] = 1'b1;
      prev = stim_val[HAND_LEN+i];
    end
  endtask

  function automatic int model_min_index();
    int k;
    int m;
    m = 0;
    for (k = 1; k < NODES; k++) begin
      if (model[k] < model[m]) m = k;
    end
    return m;
  endfunction

  function automatic data_t model_min();
    return model[model_min_index()];
  endfunction

  function automatic logic model_full();
    int k;
    int n;
    n = 0;
    for (k = 0; k < NODES; k++) begin
      if (model[k] != '0) n++;  // nonzero entries only
    end
    return (n == NODES);
  endfunction

  // ----------------------------------------------------------------------
  // compare tasks and drivers
  // ----------------------------------------------------------------------
  task automatic check_data(input data_t got, input data_t exp, input string what);
    check_count++;
    if (got !== exp) begin
      $display("ERROR @%0t: step %0d, %s: got %0d, expected %0d",
               $time, step, what, got, exp);
      error_count++;
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    check_count++;
    if (got !== exp) begin
      $display("ERROR @%0t: step %0d, %s: got %b, expected %b",
               $time, step, what, got, exp);
      error_count++;
    end
  endtask

  task automatic tick();
    @(posedge CLK);
    #2;  // drive and sample just after the edge
  endtask

  task automatic wait_idle(input int limit, input string what);
    int n;
    n = 0;
    while (o_busy && n < limit) begin
      tick();
      n++;
    end
    if (o_busy) begin
      $display("o_busy still high %0d cycles after %s, step %0d", limit, what, step);
      error_count++;
    end
  endtask

  task automatic apply_offer(input data_t value);
    data_t old_min;
    logic  take;
    wait_idle(IDLE_WAIT, "previous step");
    old_min = model_min();
    check_data(o_data, old_min, "root before offer");
    check_flag(o_full, model_full(), "full before offer");
    take   = (value > old_min);  // only a larger value enters the top K
    i_wrt  = 1'b1;
    i_data = value;
    tick();
    i_wrt = 1'b0;
    if (take) begin
      model[model_min_index()] = value;
      check_flag(o_busy, 1'b1, "busy after accepted offer");
      check_data(o_data, value, "root right after accept");
    end else begin
      check_flag(o_busy, 1'b0, "busy after rejected offer");
      check_data(o_data, old_min, "root after rejected offer");
    end
  endtask

  // pulse while a sift runs, model untouched
  task automatic apply_stray(input data_t value);
    check_flag(o_busy, 1'b1, "busy when stray pulse driven");
    i_wrt  = 1'b1;
    i_data = value;
    tick();
    i_wrt = 1'b0;
  endtask

  // ----------------------------------------------------------------------
  // main sequence
  // ----------------------------------------------------------------------
  initial begin : main
    int i;
    RSTn   = 1'b0;
    i_wrt  = 1'b0;
    i_data = '0;
    for (i = 0; i < NODES; i++) model[i] = '0;
    build_table();

    repeat (3) @(posedge CLK);
    #2;
    RSTn = 1'b1;
    check_flag(o_busy, 1'b1, "busy during ram clear");  // clear owns the ram
    check_data(o_data, '0, "root after reset");
    check_flag(o_full, 1'b0, "full after reset");
    wait_idle(IDLE_WAIT, "reset");

    for (i = 0; i < TABLE_LEN; i++) begin
      step = i;
      if (stim_offer[i]) begin
        apply_offer(stim_val[i]);
      end else begin
        apply_stray(stim_val[i]);
      end
    end

    step = TABLE_LEN;
    wait_idle(IDLE_WAIT, "last offer");
    check_data(o_data, model_min(), "final root");
    check_flag(o_full, model_full(), "final full");

    $display("checks run: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

  // cycle limit, no sift may hang the run
  initial begin : watchdog
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge CLK);
      cycle_count++;
    end
    $display("timeout: no verdict after %0d clock cycles", TIMEOUT_CYCLES);
    $display("Result: FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: tb.f
rtl/heap_pkg.sv
rtl/heap_node_ram.sv
rtl/ram_port_arbiter.sv
rtl/ram_clear_sequencer.sv
rtl/sift_down_engine.sv
rtl/topk_heap_top.sv
testbench/tb_topk_heap.sv

// File: run_sim.sh
#!/bin/sh
# build and run the top-K heap testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
  --top-module tb_topk_heap \
  -f tb.f \
  -Mdir obj_dir -o sim_topk_heap

# tee keeps the log even when the simulation stops early
./obj_dir/sim_topk_heap | tee sim.log

if grep -q "^Result: PASSED$" sim.log; then
  echo "simulation passed"
  exit 0
fi
echo "simulation failed, see sim.log"
exit 1
